//--- exu_wb_ctl.f
hw/wb_pkg.sv
hw/load_return_stage.sv
hw/pipe_valid_track.sv
hw/restore_track.sv
hw/w1_port_ctl.sv
hw/w2_port_arb.sv
hw/longop_done.sv
hw/exu_wb_ctl.sv
+incdir+test
test/tb_exu_wb_ctl.sv

//--- run_sim.sh
#!/bin/sh
# Builds the writeback control testbench with Verilator and runs it
set -u

rm -rf obj_dir sim.log

if ! verilator --binary --timing -f exu_wb_ctl.f --top-module tb_exu_wb_ctl -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
   exit 0
fi

echo "Pass line not found in sim.log"
exit 1

//--- test/tb_model.svh
// Reference port-select and completion-mask functions, included inside the writeback testbench top
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// W1 goes to the pipe first, then to a returning load, else to a restore
function automatic w1_src_e ref_w1_src(input logic pipe_active, input logic load_present);
   if (pipe_active) begin
      return W1_PIPE;
   end
   if (load_present) begin
      return W1_LOAD;
   end
   return W1_RESTORE;
endfunction

// Second port source at G
function automatic g_src_e ref_g_src(input logic pipe_active, input logic load_present,
                                     input logic restore_req);
   if (load_present && pipe_active) begin
      return G_LOAD;
   end
   if (restore_req && (load_present != pipe_active)) begin
      return G_RESTORE;
   end
   return G_MULDIV;
endfunction

// One bit set for the thread
function automatic thr_mask_t ref_done_mask(input tid_t tid);
   thr_mask_t m;
   m = '0;
   for (int t = 0; t < NUM_THREADS; t++) begin
      if (t == int'(tid)) begin
         m[t] = 1'b1;
      end
   end
   return m;
endfunction

`endif

//--- test/tb_exu_wb_ctl.sv
// Writeback control testbench with directed and LCG-driven sequences and reference checks
`timescale 1ns/1ps
`default_nettype none

module tb_exu_wb_ctl;

   import wb_pkg::*;
   `include "tb_model.svh"

   logic        clk;
   logic        rst_n;
   logic        wen_d;
   logic        return_d;
   e_ctl_t      e_ctl;
   reg_dest_t   m_dest;
   m_ctl_t      m_ctl;
   logic        inst_vld_w;
   logic        flush_w;
   load_ret_t   ld_ret;
   logic        ld_miss_g2;
   logic        flush_w1;
   tid_t        tid_w1;
   logic        muldiv_valid;
   logic        muldiv_ready;
   muldiv_res_t muldiv_res;
   thr_mask_t   swap_done;
   reg_dest_t   w1_dest_m;
   logic        w1_wen_w;
   reg_dest_t   w2_dest_g;
   logic        w2_wen_w2;
   logic        setcc_g;
   thr_mask_t   longop_done;

   // Per-cycle expectations for the compare process
   logic        chk_w1_dest;
   logic        chk_w1_wen;
   logic        chk_w2_dest;
   logic        chk_w2_wen;
   logic        chk_ready;
   logic        chk_done;
   reg_dest_t   exp_w1_dest;
   logic        exp_w1_wen;
   reg_dest_t   exp_w2_dest;
   logic        exp_w2_wen;
   logic        exp_ready;
   thr_mask_t   exp_done;
   logic [31:0] seed;

   exu_wb_ctl dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic reg_dest_t rand_dest();
      logic [31:0] r;
      r = next_rand();
      return r[22:16];
   endfunction

   ////////////////////
   // Compare tasks
   ////////////////////
   task automatic stop_on_error();
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first failure");
   endtask

   task automatic check_dest(input reg_dest_t got, input reg_dest_t exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is tid %0d rd %0d, expected tid %0d rd %0d",
                  $time, what, got.tid, got.rd, exp.tid, exp.rd);
         stop_on_error();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_mask(input thr_mask_t got, input thr_mask_t exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   // Outputs are stable one ns after the falling edge drive
   always begin
      @(negedge clk);
      #1;
      if (chk_w1_dest) check_dest(w1_dest_m, exp_w1_dest, "w1_dest_m");
      if (chk_w1_wen) check_bit(w1_wen_w, exp_w1_wen, "w1_wen_w");
      if (chk_w2_dest) check_dest(w2_dest_g, exp_w2_dest, "w2_dest_g");
      if (chk_w2_wen) check_bit(w2_wen_w2, exp_w2_wen, "w2_wen_w2");
      if (chk_ready) check_bit(muldiv_ready, exp_ready, "muldiv_ready");
      if (chk_done) check_mask(longop_done, exp_done, "longop_done");
   end

   initial begin
      repeat (4000) @(posedge clk);
      $display("Simulation ran past its cycle limit");
      stop_on_error();
   end

   // Idle values for all pulses, and no expectation armed
   task automatic clear_inputs();
      wen_d = 1'b0;
      return_d = 1'b0;
      e_ctl = '0;
      m_dest = '0;
      m_ctl = '0;
      inst_vld_w = 1'b0;
      flush_w = 1'b0;
      ld_ret = '0;
      ld_miss_g2 = 1'b0;
      flush_w1 = 1'b0;
      tid_w1 = '0;
      muldiv_valid = 1'b0;
      muldiv_res = '0;
      swap_done = '0;
      {chk_w1_dest, chk_w1_wen, chk_w2_dest, chk_w2_wen, chk_ready, chk_done} = '0;
   endtask

   // Advances to the next falling edge and returns the inputs to idle
   task automatic tick();
      @(negedge clk);
      clear_inputs();
   endtask

   ////////////////////
   // Sequences
   ////////////////////
   // Kind 0 clean, 1 E kill, 2 M kill, 3 flush_w, 4 inst_vld_w low
   task automatic write_from_pipe(input int kind);
      reg_dest_t d;
      d = rand_dest();
      tick();
      wen_d = 1'b1;
      tick();
      e_ctl.inst_vld = 1'b1;
      e_ctl.kill = (kind == 1);
      tick();
      m_dest = d;
      m_ctl.kill = (kind == 2);
      chk_w1_dest = (kind != 1);
      exp_w1_dest = d;
      tick();
      inst_vld_w = (kind != 4);
      flush_w = (kind == 3);
      chk_w1_wen = 1'b1;
      exp_w1_wen = (kind == 0);
      repeat (2) tick();
   endtask

   // Kind 0 clean, 1 miss, 2 flush same thread, 3 flush other thread
   task automatic return_load(input int kind);
      reg_dest_t d;
      d = rand_dest();
      tick();
      ld_ret = {1'b1, d};
      tick();
      ld_miss_g2 = (kind == 1);
      flush_w1 = (kind >= 2);
      tid_w1 = (kind == 3) ? d.tid + 2'd1 : d.tid;
      chk_w1_dest = (ref_w1_src(1'b0, 1'b1) == W1_LOAD);
      exp_w1_dest = d;
      chk_ready = 1'b1;
      exp_ready = (ref_g_src(1'b0, 1'b1, 1'b0) == G_MULDIV);
      tick();
      chk_w1_wen = 1'b1;
      exp_w1_wen = (kind == 0) || (kind == 3);
      tick();
   endtask

   task automatic collide_load_with_pipe();
      reg_dest_t dp;
      reg_dest_t dl;
      dp = rand_dest();
      dl = rand_dest();
      tick();
      wen_d = 1'b1;
      tick();
      e_ctl.inst_vld = 1'b1;
      ld_ret = {1'b1, dl};
      tick();
      m_dest = dp;
      chk_w1_dest = 1'b1;
      exp_w1_dest = (ref_w1_src(1'b1, 1'b1) == W1_PIPE) ? dp : dl;
      chk_w2_dest = (ref_g_src(1'b1, 1'b1, 1'b0) == G_LOAD);
      exp_w2_dest = dl;
      chk_ready = 1'b1;
      exp_ready = 1'b0;
      tick();
      inst_vld_w = 1'b1;
      {chk_w1_wen, chk_w2_wen, exp_w1_wen, exp_w2_wen} = 4'b1111;
      tick();
   endtask

   // A collision first holds the request off for one cycle
   task automatic transfer_muldiv(input logic collide);
      muldiv_res_t res;
      logic [31:0] r;
      logic        xfer;
      logic        busy;
      r = next_rand();
      res = r[8:0];
      xfer = 1'b0;
      busy = collide;
      tick();
      if (collide) begin
         wen_d = 1'b1;
         tick();
         e_ctl.inst_vld = 1'b1;
         ld_ret = {1'b1, rand_dest()};
         tick();
         m_dest = rand_dest();
      end
      for (int i = 0; i < 16 && !xfer; i++) begin
         muldiv_valid = 1'b1;
         muldiv_res = res;
         inst_vld_w = 1'b1;
         chk_ready = 1'b1;
         exp_ready = (ref_g_src(busy, busy, 1'b0) == G_MULDIV);
         #1;
         if (muldiv_ready) begin
            xfer = 1'b1;
            check_mask(longop_done, ref_done_mask(res.dest.tid), "longop_done");
            check_bit(setcc_g, res.setcc, "setcc_g");
            check_dest(w2_dest_g, res.dest, "w2_dest_g");
         end
         busy = 1'b0;
         tick();
      end
      if (!xfer) begin
         $display("Multiply/divide request was never accepted");
         stop_on_error();
      end
      chk_w2_wen = 1'b1;
      exp_w2_wen = 1'b1;
      tick();
   endtask

   // Blocked keeps both ports busy when the restore reaches W
   task automatic issue_restore(input logic flushed, input logic blocked);
      reg_dest_t d;
      logic      found;
      d = rand_dest();
      found = 1'b0;
      tick();
      wen_d = 1'b1;
      tick();
      e_ctl.inst_vld = 1'b1;
      e_ctl.restore = 1'b1;
      wen_d = blocked;
      tick();
      m_dest = d;
      if (blocked) begin
         e_ctl.inst_vld = 1'b1;
         ld_ret = {1'b1, rand_dest()};
      end
      tick();
      inst_vld_w = 1'b1;
      flush_w = flushed;
      if (blocked) m_dest = rand_dest();
      for (int i = 0; i < 12 && !found; i++) begin
         #1;
         if (flushed) begin
            check_mask(longop_done, '0, "longop_done");
         end else if (longop_done[d.tid]) begin
            found = 1'b1;
            check_mask(longop_done, ref_done_mask(d.tid), "longop_done");
            if (ref_w1_src(1'b0, 1'b0) == W1_RESTORE) check_dest(w1_dest_m, d, "w1_dest_m");
         end
         tick();
         inst_vld_w = 1'b1;
      end
      if (!flushed && !found) begin
         $display("Restore did not complete within 12 cycles");
         stop_on_error();
      end
      chk_w1_wen = !flushed;
      exp_w1_wen = 1'b1;
      tick();
   endtask

   task automatic finish_short_op(input logic trap);
      reg_dest_t   d;
      logic [31:0] r;
      d = rand_dest();
      r = next_rand();
      tick();
      e_ctl.inst_vld = 1'b1;
      e_ctl.rmlop_done = 1'b1;
      swap_done = r[3:0];
      chk_done = 1'b1;
      exp_done = r[3:0];
      tick();
      m_dest = d;
      m_ctl.trap_kill = trap;
      swap_done = r[7:4];
      chk_done = 1'b1;
      exp_done = r[7:4] | (trap ? '0 : ref_done_mask(d.tid));
      tick();
   endtask

   initial begin
      logic [31:0] r;
      seed = 32'h11b4_e8e3;
      rst_n = 1'b0;
      clear_inputs();
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_bit(w1_wen_w, 1'b0, "w1_wen_w in reset");
      check_bit(w2_wen_w2, 1'b0, "w2_wen_w2 in reset");
      check_mask(longop_done, '0, "longop_done in reset");
      rst_n = 1'b1;
      for (int k = 0; k < 5; k++) write_from_pipe(k);
      for (int k = 0; k < 4; k++) return_load(k);
      repeat (4) collide_load_with_pipe();
      for (int n = 0; n < 20; n++) begin
         r = next_rand();
         transfer_muldiv(r[20]);
      end
      issue_restore(1'b0, 1'b0);
      issue_restore(1'b0, 1'b1);
      issue_restore(1'b1, 1'b0);
      finish_short_op(1'b0);
      finish_short_op(1'b1);
      repeat (3) tick();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/exu_wb_ctl.sv
// Top of the integer writeback control, connecting valid tracking, load return, restore and port logic
`timescale 1ns/1ps
`default_nettype none

module exu_wb_ctl (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                wen_d,
   input  logic                return_d,
   input  wb_pkg::e_ctl_t      e_ctl,
   input  wb_pkg::reg_dest_t   m_dest,
   input  wb_pkg::m_ctl_t      m_ctl,
   input  logic                inst_vld_w,
   input  logic                flush_w,
   input  wb_pkg::load_ret_t   ld_ret,
   input  logic                ld_miss_g2,
   input  logic                flush_w1,
   input  wb_pkg::tid_t        tid_w1,
   input  logic                muldiv_valid,
   output logic                muldiv_ready,
   input  wb_pkg::muldiv_res_t muldiv_res,
   input  wb_pkg::thr_mask_t   swap_done,
   output wb_pkg::reg_dest_t   w1_dest_m,
   output logic                w1_wen_w,
   output wb_pkg::reg_dest_t   w2_dest_g,
   output logic                w2_wen_w2,
   output logic                setcc_g,
   output wb_pkg::thr_mask_t   longop_done
);

   import wb_pkg::*;

   logic      wb_e;
   logic      wb_m;
   logic      valid_m;
   logic      pipe_wen_w;
   logic      ld_g2;
   logic      ld_wen_g2;
   reg_dest_t ld_dest_g2;
   logic      restore_request;
   logic      restore_wen;
   reg_dest_t restore_dest;
   logic      restore_picked;
   thr_mask_t restore_done_mask;
   logic      short_done_m;
   w1_src_e   w1_src;
   logic      nonpipe_wen_w;
   thr_mask_t muldiv_done;

   pipe_valid_track u_pipe_valid_track (
      .clk, .rst_n, .wen_d, .e_ctl, .m_ctl, .flush_w, .inst_vld_w,
      .wb_e, .wb_m, .valid_m, .pipe_wen_w
   );

   load_return_stage u_load_return_stage (
      .clk, .rst_n, .ld_ret, .ld_miss_g2, .flush_w1, .tid_w1,
      .ld_g2, .ld_wen_g2, .ld_dest_g2
   );

   // M-stage restore flag is for bypass logic outside this unit
   restore_track u_restore_track (
      .clk, .rst_n, .wb_e, .return_d, .e_ctl, .m_dest, .inst_vld_w, .flush_w,
      .restore_picked, .restore_m(), .restore_request, .restore_wen, .restore_dest,
      .restore_done_mask, .short_done_m
   );

   w1_port_ctl u_w1_port_ctl (
      .clk, .rst_n, .wb_m, .valid_m, .m_dest, .ld_g2, .ld_wen_g2, .ld_dest_g2,
      .restore_wen, .restore_dest, .w1_src, .w1_dest_m, .nonpipe_wen_w
   );

   w2_port_arb u_w2_port_arb (
      .clk, .rst_n, .wb_m, .ld_g2, .ld_wen_g2, .ld_dest_g2, .restore_request,
      .restore_wen, .restore_dest, .w1_src, .muldiv_valid, .muldiv_res,
      .muldiv_ready, .w2_dest_g, .w2_wen_w2, .setcc_g, .muldiv_done, .restore_picked
   );

   longop_done u_longop_done (
      .muldiv_done, .restore_done_mask, .short_done_m, .m_dest, .m_ctl, .swap_done,
      .longop_done
   );

   // W1 write from the pipe or from a load/restore picked a cycle earlier
   assign w1_wen_w = pipe_wen_w | nonpipe_wen_w;

endmodule

`default_nettype wire

//--- hw/longop_done.sv
// Merges all long-operation completions into the per-thread done mask sent to fetch
`timescale 1ns/1ps
`default_nettype none

module longop_done (
   input  wb_pkg::thr_mask_t muldiv_done,
   input  wb_pkg::thr_mask_t restore_done_mask,
   input  logic              short_done_m,
   input  wb_pkg::reg_dest_t m_dest,
   input  wb_pkg::m_ctl_t    m_ctl,
   input  wb_pkg::thr_mask_t swap_done,
   output wb_pkg::thr_mask_t longop_done
);

   import wb_pkg::*;

   thr_mask_t short_mask;

   // Short long-ops belong to the thread now in M
   assign short_mask = (short_done_m & ~m_ctl.trap_kill) ?
                       (thr_mask_t'(1) << m_dest.tid) : '0;

   // trap_kill leaves the other sources alone
   assign longop_done = muldiv_done | restore_done_mask | short_mask | swap_done;

endmodule

`default_nettype wire

//--- hw/w2_port_arb.sv
// Arbitrates the W2 port among load, restore and multiply/divide at G, with the muldiv handshake
`timescale 1ns/1ps
`default_nettype none

module w2_port_arb (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                wb_m,
   input  logic                ld_g2,
   input  logic                ld_wen_g2,
   input  wb_pkg::reg_dest_t   ld_dest_g2,
   input  logic                restore_request,
   input  logic                restore_wen,
   input  wb_pkg::reg_dest_t   restore_dest,
   input  wb_pkg::w1_src_e     w1_src,
   input  logic                muldiv_valid,
   input  wb_pkg::muldiv_res_t muldiv_res,
   output logic                muldiv_ready,
   output wb_pkg::reg_dest_t   w2_dest_g,
   output logic                w2_wen_w2,
   output logic                setcc_g,
   output wb_pkg::thr_mask_t   muldiv_done,
   output logic                restore_picked
);

   import wb_pkg::*;

   g_src_e g_src;
   logic   muldiv_xfer;
   logic   w2_wen_g;

   // Load spills to W2 only when the pipe holds W1
   // Restore takes whichever port is left over
   always_comb begin
      if (ld_g2 & wb_m) begin
         g_src = G_LOAD;
      end else if (restore_request & (ld_g2 ^ wb_m)) begin
         g_src = G_RESTORE;
      end else begin
         g_src = G_MULDIV;
      end
   end

   assign muldiv_ready = (g_src == G_MULDIV);
   assign muldiv_xfer  = muldiv_ready & muldiv_valid;

   always_comb begin
      unique case (g_src)
         G_LOAD:    w2_dest_g = ld_dest_g2;
         G_RESTORE: w2_dest_g = restore_dest;
         G_MULDIV:  w2_dest_g = muldiv_res.dest;
         default:   w2_dest_g = muldiv_res.dest;
      endcase
   end

   assign w2_wen_g = ((g_src == G_LOAD) & ld_wen_g2) |
                     ((g_src == G_RESTORE) & restore_wen) |
                     muldiv_xfer;

   ////////////////////
   // Completion
   ////////////////////
   assign setcc_g     = muldiv_xfer & muldiv_res.setcc;
   assign muldiv_done = muldiv_xfer ? (thr_mask_t'(1) << muldiv_res.dest.tid) : '0;

   // Either port may have taken it
   assign restore_picked = restore_request &
                           ((w1_src == W1_RESTORE) | (g_src == G_RESTORE));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w2_wen_w2 <= 1'b0;
      end else begin
         w2_wen_w2 <= w2_wen_g;
      end
   end

endmodule

`default_nettype wire

//--- hw/w1_port_ctl.sv
// Picks the W1 write source, muxes its target and registers the load/restore enable into W
`timescale 1ns/1ps
`default_nettype none

module w1_port_ctl (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wb_m,
   input  logic              valid_m,
   input  wb_pkg::reg_dest_t m_dest,
   input  logic              ld_g2,
   input  logic              ld_wen_g2,
   input  wb_pkg::reg_dest_t ld_dest_g2,
   input  logic              restore_wen,
   input  wb_pkg::reg_dest_t restore_dest,
   output wb_pkg::w1_src_e   w1_src,
   output wb_pkg::reg_dest_t w1_dest_m,
   output logic              nonpipe_wen_w
);

   import wb_pkg::*;

   logic nonpipe_wen_m;

   // Priority is pipe, then load, then restore
   always_comb begin
      if (wb_m) begin
         w1_src = W1_PIPE;
      end else if (ld_g2) begin
         w1_src = W1_LOAD;
      end else begin
         w1_src = W1_RESTORE;
      end
   end

   always_comb begin
      unique case (w1_src)
         W1_PIPE:    w1_dest_m = m_dest;
         W1_LOAD:    w1_dest_m = ld_dest_g2;
         W1_RESTORE: w1_dest_m = restore_dest;
         default:    w1_dest_m = m_dest;
      endcase
   end

   // A live pipe write always owns W1
   assign nonpipe_wen_m = ~valid_m &
                          (((w1_src == W1_LOAD) & ld_wen_g2) |
                           ((w1_src == W1_RESTORE) & restore_wen));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         nonpipe_wen_w <= 1'b0;
      end else begin
         nonpipe_wen_w <= nonpipe_wen_m;
      end
   end

endmodule

`default_nettype wire

//--- hw/restore_track.sv
// Stages restores from E to W, keeps a pending restore until a port takes it, and flags short long-ops
`timescale 1ns/1ps
`default_nettype none

module restore_track (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wb_e,
   input  logic              return_d,
   input  wb_pkg::e_ctl_t    e_ctl,
   input  wb_pkg::reg_dest_t m_dest,
   input  logic              inst_vld_w,
   input  logic              flush_w,
   input  logic              restore_picked,
   output logic              restore_m,
   output logic              restore_request,
   output logic              restore_wen,
   output wb_pkg::reg_dest_t restore_dest,
   output wb_pkg::thr_mask_t restore_done_mask,
   output logic              short_done_m
);

   import wb_pkg::*;

   logic return_e;
   logic vld_restore_e;
   logic restore_w;
   logic vld_restore_w;
   logic restore_ready;
   logic restore_ready_next;
   logic short_done_e;

   // Returns switch the window back on their own
   assign vld_restore_e = e_ctl.restore & wb_e & ~return_e & ~e_ctl.fill & e_ctl.inst_vld;

   // Restore without a register write completes right away as a short long-op
   assign short_done_e = (e_ctl.rmlop_done | (e_ctl.restore & ~wb_e & ~return_e)) &
                         e_ctl.inst_vld & ~e_ctl.kill;

   assign vld_restore_w = restore_w & inst_vld_w & ~flush_w;

   ////////////////////
   // Pending restore
   ////////////////////
   assign restore_request    = restore_w | restore_ready;
   assign restore_wen        = vld_restore_w | restore_ready;
   assign restore_ready_next = (vld_restore_w | restore_ready) & ~restore_picked;

   // Done only for a restore that survived W
   assign restore_done_mask = (restore_picked & restore_wen) ?
                              (thr_mask_t'(1) << restore_dest.tid) : '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         return_e      <= 1'b0;
         restore_m     <= 1'b0;
         restore_w     <= 1'b0;
         restore_ready <= 1'b0;
         short_done_m  <= 1'b0;
      end else begin
         return_e      <= return_d;
         restore_m     <= vld_restore_e;
         restore_w     <= restore_m;
         restore_ready <= restore_ready_next;
         short_done_m  <= short_done_e;
      end
   end

   // Target is captured while the restore sits in M
   always_ff @(posedge clk) begin
      if (restore_m) begin
         restore_dest <= m_dest;
      end
   end

endmodule

`default_nettype wire

//--- hw/pipe_valid_track.sv
// Write-valid pipeline from D to W for ALU results, applying each stage's kill
`timescale 1ns/1ps
`default_nettype none

module pipe_valid_track (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           wen_d,
   input  wb_pkg::e_ctl_t e_ctl,
   input  wb_pkg::m_ctl_t m_ctl,
   input  logic           flush_w,
   input  logic           inst_vld_w,
   output logic           wb_e,
   output logic           wb_m,
   output logic           valid_m,
   output logic           pipe_wen_w
);

   logic valid_e;
   logic wb_w;

   // Restores finish late through the restore path, not here
   assign valid_e = wb_e & ~e_ctl.kill & ~e_ctl.restore;

   // Spill/fill trap at M
   assign valid_m = wb_m & ~m_ctl.kill;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_e <= 1'b0;
         wb_m <= 1'b0;
         wb_w <= 1'b0;
      end else begin
         wb_e <= wen_d;
         wb_m <= valid_e;
         wb_w <= valid_m;
      end
   end

   ////////////////////
   // W stage
   ////////////////////
   // Flush and instruction valid are only known at W
   assign pipe_wen_w = inst_vld_w & wb_w & ~flush_w;

endmodule

`default_nettype wire

//--- hw/load_return_stage.sv
// Holds a returning load for one cycle into G2 and qualifies it against misses and W1 flushes
`timescale 1ns/1ps
`default_nettype none

module load_return_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  wb_pkg::load_ret_t ld_ret,
   input  logic              ld_miss_g2,
   input  logic              flush_w1,
   input  wb_pkg::tid_t      tid_w1,
   output logic              ld_g2,
   output logic              ld_wen_g2,
   output wb_pkg::reg_dest_t ld_dest_g2
);

   logic flush_kill_g2;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_g2 <= 1'b0;
      end else begin
         ld_g2 <= ld_ret.vld;
      end
   end

   // Target rides along with the valid
   always_ff @(posedge clk) begin
      ld_dest_g2 <= ld_ret.dest;
   end

   // W1 flush only hits the load of the same thread
   assign flush_kill_g2 = flush_w1 & (tid_w1 == ld_dest_g2.tid);
   assign ld_wen_g2     = ld_g2 & ~ld_miss_g2 & ~flush_kill_g2;

endmodule

`default_nettype wire

//--- hw/wb_pkg.sv
// Shared widths, write-target structs and port-select encodings, imported by every writeback block
`default_nettype none

package wb_pkg;

   ////////////////////
   // Sizes
   ////////////////////
   localparam int NUM_THREADS = 4;
   localparam int TID_W       = 2;
   localparam int RD_W        = 5;

   typedef logic [TID_W-1:0]       tid_t;
   typedef logic [RD_W-1:0]        rd_t;
   typedef logic [NUM_THREADS-1:0] thr_mask_t;

   // Target of one register file write
   typedef struct packed {
      tid_t tid;
      rd_t  rd;
   } reg_dest_t;

   ////////////////////
   // Input bundles
   ////////////////////
   typedef struct packed {
      logic      vld;
      reg_dest_t dest;
   } load_ret_t;

   typedef struct packed {
      reg_dest_t dest;
      logic      setcc;
      logic      is_div;
   } muldiv_res_t;

   typedef struct packed {
      logic inst_vld;
      logic kill;
      logic restore;
      logic fill;
      logic rmlop_done;
   } e_ctl_t;

   typedef struct packed {
      logic kill;        // spill/fill trap
      logic trap_kill;   // kills short long-op completion only
   } m_ctl_t;

   ////////////////////
   // Port selects
   ////////////////////
   typedef enum logic [1:0] {
      W1_PIPE,
      W1_LOAD,
      W1_RESTORE
   } w1_src_e;

   typedef enum logic [1:0] {
      G_LOAD,
      G_RESTORE,
      G_MULDIV
   } g_src_e;

endpackage

`default_nettype wire
